// ==== segDisplayPkg.sv ====
package segDisplayPkg;

    // ======================================================================
    // Bus and register map
    // ======================================================================
    localparam int DataWidth = 32;
    localparam int AddrWidth = 8;
    localparam int LaneCount = 4;

    localparam logic [AddrWidth-1:0] DigitAddr = 8'd0;
    localparam logic [AddrWidth-1:0] CtrlAddr  = 8'd1;

    // ======================================================================
    // Digit byte layout
    // ======================================================================
    localparam int DigitCount = 4;
    localparam int DigitBits  = 8;

    // Hex value, decimal point and enable within one digit byte.
    localparam int ValueLsb   = 0;
    localparam int ValueWidth = 4;
    localparam int DotBit     = 4;
    localparam int EnableBit  = 5;

    // ======================================================================
    // Control register and reset values
    // ======================================================================
    localparam int ModeWidth = 4;

    // Modes 0 to 3 light a single digit, this one cycles through all of them.
    localparam logic [ModeWidth-1:0] ModeScan = 4'd15;

    localparam logic [DataWidth-1:0] DigitReset = 32'h0000_0000;
    localparam logic [DataWidth-1:0] CtrlReset  = 32'h0000_0001;

    // ======================================================================
    // Display outputs and timing
    // ======================================================================
    // Segments a to g on bits 0 to 6, dot on bit 7, high means lit.
    localparam int SegWidth = 8;

    // Digit selects are active low.
    localparam logic [DigitCount-1:0] SelBlank = '1;

    localparam int ScanDivideDefault = 65536;

endpackage

// ==== digitDecoder.sv ====
`timescale 1ns/1ps

module digitDecoder (
    input  logic [segDisplayPkg::ValueWidth-1:0] value,
    input  logic                                 dot,
    input  logic                                 enable,
    output logic [segDisplayPkg::SegWidth-1:0]   seg
);

    logic [6:0] glyph;

    // Segment order is g f e d c b a, msb first.
    always_comb begin
        case (value)
            4'h0: glyph = 7'b011_1111;
            4'h1: glyph = 7'b000_0110;
            4'h2: glyph = 7'b101_1011;
            4'h3: glyph = 7'b100_1111;
            4'h4: glyph = 7'b110_0110;
            4'h5: glyph = 7'b110_1101;
            4'h6: glyph = 7'b111_1101;
            4'h7: glyph = 7'b000_0111;
            4'h8: glyph = 7'b111_1111;
            4'h9: glyph = 7'b110_1111;
            4'hA: glyph = 7'b111_0111;
            4'hB: glyph = 7'b111_1100;
            4'hC: glyph = 7'b011_1001;
            4'hD: glyph = 7'b101_1110;
            4'hE: glyph = 7'b111_1001;
            4'hF: glyph = 7'b111_0001;
            default: glyph = 7'b000_0000;
        endcase
    end

    // A disabled digit stays dark, dot included.
    always_comb begin
        if (enable) begin
            seg = {dot, glyph};
        end else begin
            seg = '0;
        end
    end

endmodule

// ==== scanTimer.sv ====
`timescale 1ns/1ps

module scanTimer #(
    parameter int ScanDivide = segDisplayPkg::ScanDivideDefault
) (
    input  logic clk,
    input  logic rstn,
    output logic scanTick
);

    localparam int CountWidth = (ScanDivide > 1) ? $clog2(ScanDivide) : 1;
    localparam logic [CountWidth-1:0] CountLast = CountWidth'(ScanDivide - 1);

    logic [CountWidth-1:0] count;
    logic                  wrap;

    assign wrap = (count == CountLast);

    // Free-running divider inside the clk domain.
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            count <= '0;
        end else if (wrap) begin
            count <= '0;
        end else begin
            count <= count + 1'b1;
        end
    end

    // One-cycle pulse on the wrap cycle.
    assign scanTick = wrap;

endmodule

// ==== displayRegs.sv ====
`timescale 1ns/1ps

module displayRegs (
    input  logic                                 clk,
    input  logic                                 rstn,
    input  logic [segDisplayPkg::AddrWidth-1:0]  addrIn,
    input  logic [segDisplayPkg::LaneCount-1:0]  sizeDecode,
    input  logic [segDisplayPkg::DataWidth-1:0]  dataIn,
    input  logic [segDisplayPkg::AddrWidth-1:0]  addrOut,
    output logic [segDisplayPkg::DataWidth-1:0]  dataOut,
    output logic [segDisplayPkg::DataWidth-1:0]  digitWord,
    output logic [segDisplayPkg::DataWidth-1:0]  ctrlWord
);

    import segDisplayPkg::*;

    localparam int LaneBits = DataWidth / LaneCount;

    logic [DataWidth-1:0] digitReg;
    logic [DataWidth-1:0] ctrlReg;
    logic [DataWidth-1:0] readData;
    logic                 digitHit;
    logic                 ctrlHit;

    // ======================================================================
    // Write side
    // ======================================================================
    assign digitHit = (addrIn == DigitAddr);
    assign ctrlHit  = (addrIn == CtrlAddr);

    // Each strobed byte lane loads on its own.
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            digitReg <= DigitReset;
        end else if (digitHit) begin
            for (int lane = 0; lane < LaneCount; lane++) begin
                if (sizeDecode[lane]) begin
                    digitReg[lane*LaneBits +: LaneBits] <= dataIn[lane*LaneBits +: LaneBits];
                end
            end
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            ctrlReg <= CtrlReset;
        end else if (ctrlHit) begin
            for (int lane = 0; lane < LaneCount; lane++) begin
                if (sizeDecode[lane]) begin
                    ctrlReg[lane*LaneBits +: LaneBits] <= dataIn[lane*LaneBits +: LaneBits];
                end
            end
        end
    end

    // ======================================================================
    // Read side
    // ======================================================================
    // Unmapped addresses read as zero.
    always_comb begin
        if (addrOut == DigitAddr) begin
            readData = digitReg;
        end else if (addrOut == CtrlAddr) begin
            readData = ctrlReg;
        end else begin
            readData = '0;
        end
    end

    // Registered, so a same-edge write returns the old contents.
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            dataOut <= '0;
        end else begin
            dataOut <= readData;
        end
    end

    assign digitWord = digitReg;
    assign ctrlWord  = ctrlReg;

endmodule

// ==== displayScanner.sv ====
`timescale 1ns/1ps

module displayScanner (
    input  logic                                 clk,
    input  logic                                 rstn,
    input  logic                                 scanTick,
    input  logic [segDisplayPkg::ModeWidth-1:0]  mode,
    input  logic [segDisplayPkg::SegWidth-1:0]   seg0,
    input  logic [segDisplayPkg::SegWidth-1:0]   seg1,
    input  logic [segDisplayPkg::SegWidth-1:0]   seg2,
    input  logic [segDisplayPkg::SegWidth-1:0]   seg3,
    output logic [segDisplayPkg::SegWidth-1:0]   seg,
    output logic [segDisplayPkg::DigitCount-1:0] segSel
);

    import segDisplayPkg::*;

    localparam int PosWidth = $clog2(DigitCount);

    logic [PosWidth-1:0]   scanPos;
    logic [PosWidth-1:0]   digitIdx;
    logic                  showDigit;
    logic                  scanMode;
    logic [SegWidth-1:0]   pickSeg;
    logic [DigitCount-1:0] pickSel;

    assign scanMode = (mode == ModeScan);

    // ======================================================================
    // Digit selection
    // ======================================================================
    always_comb begin
        showDigit = 1'b0;
        digitIdx  = mode[PosWidth-1:0];
        if (scanMode) begin
            showDigit = 1'b1;
            digitIdx  = scanPos;
        end else if (mode < ModeWidth'(DigitCount)) begin
            showDigit = 1'b1;
        end
    end

    always_comb begin
        case (digitIdx)
            2'd0: pickSeg = seg0;
            2'd1: pickSeg = seg1;
            2'd2: pickSeg = seg2;
            default: pickSeg = seg3;
        endcase
    end

    // Active-low one-hot select, or nothing in blank modes.
    always_comb begin
        if (showDigit) begin
            pickSel = ~(DigitCount'(1) << digitIdx);
        end else begin
            pickSel = SelBlank;
        end
    end

    // ======================================================================
    // Output registers
    // ======================================================================
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            seg    <= '0;
            segSel <= SelBlank;
        end else if (scanTick) begin
            segSel <= pickSel;
            if (showDigit) begin
                seg <= pickSeg;
            end else begin
                seg <= '0;
            end
        end
    end

    // Position only moves in scan mode and holds otherwise.
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            scanPos <= '0;
        end else if (scanTick && scanMode) begin
            scanPos <= scanPos + 1'b1;
        end
    end

endmodule

// ==== segDisplay.sv ====
`timescale 1ns/1ps

module segDisplay #(
    parameter int ScanDivide = segDisplayPkg::ScanDivideDefault
) (
    input  logic                                 clk,
    input  logic                                 rstn,
    input  logic [segDisplayPkg::AddrWidth-1:0]  addrIn,
    input  logic [segDisplayPkg::AddrWidth-1:0]  addrOut,
    input  logic [segDisplayPkg::LaneCount-1:0]  sizeDecode,
    input  logic [segDisplayPkg::DataWidth-1:0]  dataIn,
    output logic [segDisplayPkg::DataWidth-1:0]  dataOut,
    output logic [segDisplayPkg::SegWidth-1:0]   seg,
    output logic [segDisplayPkg::DigitCount-1:0] segSel
);

    import segDisplayPkg::*;

    logic [DataWidth-1:0] digitWord;
    logic [DataWidth-1:0] ctrlWord;
    logic [SegWidth-1:0]  seg0;
    logic [SegWidth-1:0]  seg1;
    logic [SegWidth-1:0]  seg2;
    logic [SegWidth-1:0]  seg3;
    logic                 scanTick;

    displayRegs regs (
        .clk        (clk),
        .rstn       (rstn),
        .addrIn     (addrIn),
        .sizeDecode (sizeDecode),
        .dataIn     (dataIn),
        .addrOut    (addrOut),
        .dataOut    (dataOut),
        .digitWord  (digitWord),
        .ctrlWord   (ctrlWord)
    );

    // One decoder per byte of the digit register.
    digitDecoder dec0 (
        .value  (digitWord[0*DigitBits+ValueLsb +: ValueWidth]),
        .dot    (digitWord[0*DigitBits+DotBit]),
        .enable (digitWord[0*DigitBits+EnableBit]),
        .seg    (seg0)
    );

    digitDecoder dec1 (
        .value  (digitWord[1*DigitBits+ValueLsb +: ValueWidth]),
        .dot    (digitWord[1*DigitBits+DotBit]),
        .enable (digitWord[1*DigitBits+EnableBit]),
        .seg    (seg1)
    );

    digitDecoder dec2 (
        .value  (digitWord[2*DigitBits+ValueLsb +: ValueWidth]),
        .dot    (digitWord[2*DigitBits+DotBit]),
        .enable (digitWord[2*DigitBits+EnableBit]),
        .seg    (seg2)
    );

    digitDecoder dec3 (
        .value  (digitWord[3*DigitBits+ValueLsb +: ValueWidth]),
        .dot    (digitWord[3*DigitBits+DotBit]),
        .enable (digitWord[3*DigitBits+EnableBit]),
        .seg    (seg3)
    );

    scanTimer #(
        .ScanDivide (ScanDivide)
    ) timer (
        .clk      (clk),
        .rstn     (rstn),
        .scanTick (scanTick)
    );

    displayScanner scanner (
        .clk      (clk),
        .rstn     (rstn),
        .scanTick (scanTick),
        .mode     (ctrlWord[ModeWidth-1:0]),
        .seg0     (seg0),
        .seg1     (seg1),
        .seg2     (seg2),
        .seg3     (seg3),
        .seg      (seg),
        .segSel   (segSel)
    );

endmodule

// ==== segDisplayChecker.sv ====
`timescale 1ns/1ps

module segDisplayChecker #(
    parameter int ScanDivide = 8
) (
    input  logic                                 clk,
    input  logic                                 rstn,
    input  logic [segDisplayPkg::AddrWidth-1:0]  addrIn,
    input  logic [segDisplayPkg::AddrWidth-1:0]  addrOut,
    input  logic [segDisplayPkg::LaneCount-1:0]  sizeDecode,
    input  logic [segDisplayPkg::DataWidth-1:0]  dataIn,
    input  logic [segDisplayPkg::DataWidth-1:0]  dataOut,
    input  logic [segDisplayPkg::SegWidth-1:0]   seg,
    input  logic [segDisplayPkg::DigitCount-1:0] segSel,
    input  logic [segDisplayPkg::DataWidth-1:0]  expRead,
    input  logic                                 expValid,
    output int                                   errorCount,
    output int                                   checkCount
);

    import segDisplayPkg::*;

    logic [DataWidth-1:0]  digitModel;
    logic [DataWidth-1:0]  ctrlModel;
    logic [DataWidth-1:0]  expData;
    logic [SegWidth-1:0]   expSeg;
    logic [DigitCount-1:0] expSel;
    int                    scanPos;
    int                    cycles;

    initial begin
        errorCount = 0;
        checkCount = 0;
    end

    // Standard hex glyphs, bit 0 is segment a.
    function automatic logic [6:0] hexGlyph(input logic [3:0] v);
        logic [6:0] table16 [16];
        table16 = '{7'h3F, 7'h06, 7'h5B, 7'h4F, 7'h66, 7'h6D, 7'h7D, 7'h07,
                    7'h7F, 7'h6F, 7'h77, 7'h7C, 7'h39, 7'h5E, 7'h79, 7'h71};
        return table16[v];
    endfunction

    function automatic logic [SegWidth-1:0] digitSegs(input logic [DigitBits-1:0] b);
        if (!b[EnableBit]) begin
            return '0;
        end
        return {b[DotBit], hexGlyph(b[ValueLsb +: ValueWidth])};
    endfunction

    function automatic logic [DataWidth-1:0] mergeLanes(input logic [DataWidth-1:0] old,
                                                        input logic [DataWidth-1:0] data,
                                                        input logic [LaneCount-1:0] strobes);
        logic [DataWidth-1:0] result;
        result = old;
        for (int lane = 0; lane < LaneCount; lane++) begin
            if (strobes[lane]) begin
                result[lane*8 +: 8] = data[lane*8 +: 8];
            end
        end
        return result;
    endfunction

    task automatic compare(input string name, input logic [DataWidth-1:0] exp,
                           input logic [DataWidth-1:0] act);
        checkCount++;
        if (act !== exp) begin
            errorCount++;
            $display("FAIL at %0t ns: %s expected %h, actual %h", $time, name, exp, act);
        end
    endtask

    // ======================================================================
    // Model, stepped between edges while all signals are stable
    // ======================================================================
    always @(negedge clk) begin : modelStep
        logic [ModeWidth-1:0] mode;
        int                   idx;
        if (!rstn) begin
            digitModel = DigitReset;
            ctrlModel  = CtrlReset;
            expData    = '0;
            expSeg     = '0;
            expSel     = SelBlank;
            scanPos    = 0;
            cycles     = 0;
        end
        compare("dataOut", expData, dataOut);
        compare("seg", expSeg, seg);
        compare("segSel", expSel, segSel);
        if (expValid) begin
            compare("dataOut (table)", expRead, dataOut);
        end
        if (rstn) begin
            mode = ctrlModel[ModeWidth-1:0];
            // The next edge is a tick edge.
            if (cycles % ScanDivide == ScanDivide - 1) begin
                idx = (mode == ModeScan) ? scanPos : int'(mode);
                if (mode == ModeScan || mode < DigitCount) begin
                    expSeg = digitSegs(digitModel[idx*DigitBits +: DigitBits]);
                    expSel = ~(4'b0001 << idx);
                end else begin
                    expSeg = '0;
                    expSel = SelBlank;
                end
                if (mode == ModeScan) begin
                    scanPos = (scanPos + 1) % DigitCount;
                end
            end
            if (addrOut == DigitAddr) begin
                expData = digitModel;
            end else if (addrOut == CtrlAddr) begin
                expData = ctrlModel;
            end else begin
                expData = '0;
            end
            if (addrIn == DigitAddr) begin
                digitModel = mergeLanes(digitModel, dataIn, sizeDecode);
            end else if (addrIn == CtrlAddr) begin
                ctrlModel = mergeLanes(ctrlModel, dataIn, sizeDecode);
            end
            cycles++;
        end
    end

endmodule

// ==== segDisplayTb.sv ====
`timescale 1ns/1ps

module segDisplayTb;

    import segDisplayPkg::*;

    localparam int ClkPeriod   = 40;
    localparam int DriveDelay  = 5;
    localparam int TbDivide    = 8;
    localparam int IdleCycles  = (DigitCount + 1) * TbDivide;
    localparam int EntryCycles = IdleCycles + 1;
    localparam int FixedCount  = 25;
    localparam int RandomCount = 8;
    localparam int EntryCount  = FixedCount + RandomCount;
    localparam int TimeoutNs   = (EntryCount * EntryCycles + 50) * ClkPeriod;
    localparam logic [15:0] LfsrSeed = 16'd20143;
    localparam logic [AddrWidth-1:0] IdleAddr = 8'h80;

    logic                  clk;
    logic                  rstn;
    logic [AddrWidth-1:0]  addrIn;
    logic [AddrWidth-1:0]  addrOut;
    logic [LaneCount-1:0]  sizeDecode;
    logic [DataWidth-1:0]  dataIn;
    logic [DataWidth-1:0]  dataOut;
    logic [SegWidth-1:0]   seg;
    logic [DigitCount-1:0] segSel;
    logic [DataWidth-1:0]  expRead;
    logic                  expValid;
    int                    errorCount;
    int                    checkCount;

    // Stimulus table with the expected register readback per entry.
    logic [AddrWidth-1:0] wrAddrTab [EntryCount];
    logic [LaneCount-1:0] strobeTab [EntryCount];
    logic [DataWidth-1:0] dataTab   [EntryCount];
    logic [AddrWidth-1:0] rdAddrTab [EntryCount];
    logic [DataWidth-1:0] expTab    [EntryCount];
    logic                 chkTab    [EntryCount];
    int                   tableSize;
    logic [15:0]          lfsrState;

    segDisplay #(
        .ScanDivide (TbDivide)
    ) uut (
        .clk        (clk),
        .rstn       (rstn),
        .addrIn     (addrIn),
        .addrOut    (addrOut),
        .sizeDecode (sizeDecode),
        .dataIn     (dataIn),
        .dataOut    (dataOut),
        .seg        (seg),
        .segSel     (segSel)
    );

    segDisplayChecker #(
        .ScanDivide (TbDivide)
    ) scoreboard (
        .clk        (clk),
        .rstn       (rstn),
        .addrIn     (addrIn),
        .addrOut    (addrOut),
        .sizeDecode (sizeDecode),
        .dataIn     (dataIn),
        .dataOut    (dataOut),
        .seg        (seg),
        .segSel     (segSel),
        .expRead    (expRead),
        .expValid   (expValid),
        .errorCount (errorCount),
        .checkCount (checkCount)
    );

    initial begin
        clk = 1'b0;
    end

    always #(ClkPeriod / 2) clk = ~clk;

    // Taps 16, 14, 13, 11.
    function automatic logic [15:0] lfsrNext(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic drawBits(input int count, output logic [DataWidth-1:0] bits);
        bits = '0;
        for (int i = 0; i < count; i++) begin
            bits      = {bits[DataWidth-2:0], lfsrState[15]};
            lfsrState = lfsrNext(lfsrState);
        end
    endtask

    task automatic addEntry(input logic [AddrWidth-1:0] wa, input logic [LaneCount-1:0] st,
                            input logic [DataWidth-1:0] d, input logic [AddrWidth-1:0] ra,
                            input logic [DataWidth-1:0] exp, input logic chk);
        wrAddrTab[tableSize] = wa;
        strobeTab[tableSize] = st;
        dataTab[tableSize]   = d;
        rdAddrTab[tableSize] = ra;
        expTab[tableSize]    = exp;
        chkTab[tableSize]    = chk;
        tableSize++;
    endtask

    // ======================================================================
    // Table
    // ======================================================================
    task automatic buildTable();
        logic [DataWidth-1:0] pick;
        logic [DataWidth-1:0] strobeBits;
        logic [DataWidth-1:0] dataBits;
        logic [AddrWidth-1:0] addr;
        addEntry(8'h10, 4'hF, 32'hFFFF_FFFF, 8'h10, 32'h0000_0000, 1'b1);
        addEntry(DigitAddr, 4'hF, 32'h2322_2120, DigitAddr, 32'h2322_2120, 1'b1);
        addEntry(CtrlAddr, 4'h1, 32'h0000_0000, CtrlAddr, 32'h0000_0000, 1'b1);
        addEntry(DigitAddr, 4'h1, 32'h0000_0034, DigitAddr, 32'h2322_2134, 1'b1);
        addEntry(CtrlAddr, 4'h1, 32'h0000_0002, CtrlAddr, 32'h0000_0002, 1'b1);
        addEntry(DigitAddr, 4'h4, 32'h0025_0000, DigitAddr, 32'h2325_2134, 1'b1);
        addEntry(DigitAddr, 4'h4, 32'h0036_0000, DigitAddr, 32'h2336_2134, 1'b1);
        addEntry(DigitAddr, 4'h4, 32'h0027_0000, DigitAddr, 32'h2327_2134, 1'b1);
        addEntry(CtrlAddr, 4'h3, 32'h0000_AB03, CtrlAddr, 32'h0000_AB03, 1'b1);
        addEntry(DigitAddr, 4'h8, 32'h3800_0000, DigitAddr, 32'h3827_2134, 1'b1);
        addEntry(DigitAddr, 4'h8, 32'h2900_0000, DigitAddr, 32'h2927_2134, 1'b1);
        addEntry(DigitAddr, 4'h8, 32'h3A00_0000, DigitAddr, 32'h3A27_2134, 1'b1);
        addEntry(CtrlAddr, 4'h1, 32'hFFFF_FF01, CtrlAddr, 32'h0000_AB01, 1'b1);
        addEntry(DigitAddr, 4'h2, 32'h0000_2B00, DigitAddr, 32'h3A27_2B34, 1'b1);
        addEntry(DigitAddr, 4'h2, 32'h0000_3C00, DigitAddr, 32'h3A27_3C34, 1'b1);
        addEntry(DigitAddr, 4'h2, 32'h0000_2D00, DigitAddr, 32'h3A27_2D34, 1'b1);
        addEntry(DigitAddr, 4'h2, 32'h0000_3E00, DigitAddr, 32'h3A27_3E34, 1'b1);
        addEntry(DigitAddr, 4'h2, 32'h0000_2F00, DigitAddr, 32'h3A27_2F34, 1'b1);
        // Shown digit loses its enable.
        addEntry(DigitAddr, 4'h2, 32'h0000_0F00, DigitAddr, 32'h3A27_0F34, 1'b1);
        addEntry(CtrlAddr, 4'h1, 32'h0000_000F, CtrlAddr, 32'h0000_AB0F, 1'b1);
        addEntry(DigitAddr, 4'hF, 32'h2825_2E31, DigitAddr, 32'h2825_2E31, 1'b1);
        addEntry(CtrlAddr, 4'h1, 32'h0000_000C, CtrlAddr, 32'h0000_AB0C, 1'b1);
        addEntry(CtrlAddr, 4'h1, 32'h0000_0007, CtrlAddr, 32'h0000_AB07, 1'b1);
        addEntry(8'h02, 4'hF, 32'h1234_5678, 8'h02, 32'h0000_0000, 1'b1);
        addEntry(IdleAddr, 4'h0, 32'h0000_0000, DigitAddr, 32'h2825_2E31, 1'b1);
        // Random entries rely on the model alone.
        for (int r = 0; r < RandomCount; r++) begin
            drawBits(1, pick);
            drawBits(LaneCount, strobeBits);
            drawBits(DataWidth, dataBits);
            addr = pick[0] ? CtrlAddr : DigitAddr;
            addEntry(addr, strobeBits[LaneCount-1:0], dataBits, addr, '0, 1'b0);
        end
    endtask

    task automatic applyEntry(input int i);
        @(posedge clk);
        #(DriveDelay);
        addrIn     = wrAddrTab[i];
        sizeDecode = strobeTab[i];
        dataIn     = dataTab[i];
        addrOut    = rdAddrTab[i];
        expValid   = 1'b0;
        for (int k = 0; k < IdleCycles; k++) begin
            @(posedge clk);
            #(DriveDelay);
            addrIn     = IdleAddr;
            sizeDecode = '0;
            if (k >= 1) begin
                expRead  = expTab[i];
                expValid = chkTab[i];
            end
        end
    endtask

    initial begin
        rstn       = 1'b0;
        addrIn     = IdleAddr;
        addrOut    = DigitAddr;
        sizeDecode = '0;
        dataIn     = '0;
        expRead    = '0;
        expValid   = 1'b0;
        lfsrState  = LfsrSeed;
        tableSize  = 0;
        buildTable();
        repeat (3) @(posedge clk);
        #(DriveDelay);
        rstn = 1'b1;
        for (int i = 0; i < tableSize; i++) begin
            applyEntry(i);
        end
        repeat (2) @(posedge clk);
        #1;
        $display("Checks: %0d, errors: %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

    initial begin
        #(TimeoutNs);
        $display("Timeout: the stimulus table did not finish before the watchdog expired.");
        $display("=== FAIL ===");
        $finish;
    end

endmodule

// ==== segDisplay.f ====
segDisplayPkg.sv
digitDecoder.sv
scanTimer.sv
displayRegs.sv
displayScanner.sv
segDisplay.sv
segDisplayChecker.sv
segDisplayTb.sv
